// File: src/alu_pkg.sv
package alu_pkg;

        // Datapath and register file sizes
        localparam int data_width     = 16;
        localparam int reg_count      = 8;
        localparam int reg_addr_width = $clog2(reg_count);
        localparam int op_width       = 4;
        localparam int imm_width      = 6;

        // Opcodes
        localparam logic [op_width-1:0] op_rot_l  = 4'b0000;
        localparam logic [op_width-1:0] op_shft_l = 4'b0001;
        localparam logic [op_width-1:0] op_rot_r  = 4'b0010;
        localparam logic [op_width-1:0] op_shft_r = 4'b0011;
        localparam logic [op_width-1:0] op_add    = 4'b0100;
        localparam logic [op_width-1:0] op_or     = 4'b0101;
        localparam logic [op_width-1:0] op_xor    = 4'b0110;
        localparam logic [op_width-1:0] op_and    = 4'b0111;
        localparam logic [op_width-1:0] op_btr    = 4'b1000;
        localparam logic [op_width-1:0] op_lbi    = 4'b1001;
        localparam logic [op_width-1:0] op_slbi   = 4'b1010;
        localparam logic [op_width-1:0] op_nop    = 4'b1111;

        // Register form, fn holds invert and sign controls
        typedef struct packed {
                logic [op_width-1:0]       op;
                logic [reg_addr_width-1:0] rd;
                logic [reg_addr_width-1:0] rs;
                logic [reg_addr_width-1:0] rt;
                logic [2:0]                fn;
        } inst_rrr_t;

        // Immediate form
        typedef struct packed {
                logic [op_width-1:0]       op;
                logic [reg_addr_width-1:0] rd;
                logic [reg_addr_width-1:0] rs;
                logic [imm_width-1:0]      imm;
        } inst_ri_t;

        typedef union packed {
                inst_rrr_t rrr;
                inst_ri_t  ri;
        } inst_t;

        typedef struct packed {
                logic                      valid;
                logic [op_width-1:0]       op;
                logic [reg_addr_width-1:0] rd;
                logic [reg_addr_width-1:0] a_reg;
                logic [reg_addr_width-1:0] b_reg;
                logic                      b_is_imm;
                logic [data_width-1:0]     a_val;
                logic [data_width-1:0]     b_val;
                logic                      inv_a;
                logic                      inv_b;
                logic                      cin;
                logic                      sign;
                logic                      wb_en;
        } dec_op_t;

        typedef struct packed {
                logic                      valid;
                logic [reg_addr_width-1:0] rd;
                logic [data_width-1:0]     data;
                logic                      wb_en;
                logic                      ofl;
                logic                      z;
                logic                      n;
        } wb_t;

endpackage

// File: src/regfile.sv
module regfile
        import alu_pkg::*;
(
        input  logic                      clk,
        input  logic                      reset,
        input  logic [reg_addr_width-1:0] ra_addr,
        input  logic [reg_addr_width-1:0] rb_addr,
        output logic [data_width-1:0]     ra_data,
        output logic [data_width-1:0]     rb_data,
        input  wb_t                       wr
);

        logic [data_width-1:0] regs [reg_count];
        logic                  wr_en;

        assign wr_en = wr.valid & wr.wb_en;

        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 0; i < reg_count; i++) begin
                                regs[i] <= '0;
                        end
                end else if (wr_en) begin
                        regs[wr.rd] <= wr.data;
                end
        end

        // Write-through so a read in the write cycle sees the new value
        always_comb begin
                ra_data = regs[ra_addr];
                rb_data = regs[rb_addr];
                if (wr_en && wr.rd == ra_addr) begin
                        ra_data = wr.data;
                end
                if (wr_en && wr.rd == rb_addr) begin
                        rb_data = wr.data;
                end
        end

        // Writeback from the ALU stage must be fully known
        a_wr_known: assert property (
                @(posedge clk) disable iff (reset)
                wr_en |-> !$isunknown({wr.rd, wr.data})
        ) else $error("regfile: unknown write to r%0d", wr.rd);

endmodule

// File: src/inst_decode.sv
module inst_decode
        import alu_pkg::*;
(
        input  logic                      inst_valid,
        input  inst_t                     inst,
        output logic [reg_addr_width-1:0] ra_addr,
        output logic [reg_addr_width-1:0] rb_addr,
        input  logic [data_width-1:0]     ra_data,
        input  logic [data_width-1:0]     rb_data,
        output dec_op_t                   dec
);

        logic [op_width-1:0]   op;
        logic                  is_ri;
        logic [data_width-1:0] imm_ext;

        // rs sits in the same bits in both views
        assign ra_addr = inst.ri.rs;
        assign rb_addr = inst.rrr.rt;

        // Undefined opcodes fall back to nop
        always_comb begin
                case (inst.rrr.op)
                        op_rot_l, op_shft_l, op_rot_r, op_shft_r,
                        op_add, op_or, op_xor, op_and,
                        op_btr, op_lbi, op_slbi: op = inst.rrr.op;
                        default:                 op = op_nop;
                endcase
        end

        assign is_ri = (op == op_rot_l) || (op == op_shft_l) ||
                       (op == op_rot_r) || (op == op_shft_r) ||
                       (op == op_lbi)   || (op == op_slbi);

        // Only lbi sign-extends its immediate
        assign imm_ext = (op == op_lbi) ?
                         {{(data_width-imm_width){inst.ri.imm[imm_width-1]}}, inst.ri.imm} :
                         {{(data_width-imm_width){1'b0}}, inst.ri.imm};

        always_comb begin
                dec.valid    = inst_valid;
                dec.op       = op;
                dec.rd       = inst.rrr.rd;
                dec.a_reg    = inst.rrr.rs;
                dec.b_reg    = inst.rrr.rt;
                dec.b_is_imm = is_ri;
                dec.a_val    = ra_data;
                dec.b_val    = is_ri ? imm_ext : rb_data;

                if (is_ri) begin
                        dec.inv_a = 1'b0;
                        dec.inv_b = 1'b0;
                        dec.sign  = 1'b1;
                end else begin
                        dec.inv_a = inst.rrr.fn[2];
                        dec.inv_b = inst.rrr.fn[1];
                        dec.sign  = inst.rrr.fn[0];
                end

                // Carry in completes the two's complement of an inverted operand
                dec.cin   = dec.inv_a | dec.inv_b;
                dec.wb_en = (op != op_nop);
        end

endmodule

// File: src/exec_reg.sv
module exec_reg
        import alu_pkg::*;
(
        input  logic    clk,
        input  logic    reset,
        input  dec_op_t dec,
        input  wb_t     fwd,
        output dec_op_t ex
);

        dec_op_t nxt;
        logic    fwd_live;

        assign fwd_live = fwd.valid & fwd.wb_en;

        // Take the executing result over a stale register read
        always_comb begin
                nxt = dec;
                if (fwd_live && fwd.rd == dec.a_reg) begin
                        nxt.a_val = fwd.data;
                end
                if (fwd_live && !dec.b_is_imm && fwd.rd == dec.b_reg) begin
                        nxt.b_val = fwd.data;
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        ex.valid <= 1'b0;
                        ex.wb_en <= 1'b0;
                end else begin
                        ex <= nxt;
                end
        end

        a_ex_idle_after_reset: assert property (
                @(posedge clk) $past(reset) |-> !ex.valid
        ) else $error("exec_reg: valid operation right after reset");

endmodule

// File: src/alu.sv
module alu
        import alu_pkg::*;
(
        input  logic    clk,
        input  logic    reset,
        input  dec_op_t ex,
        output wb_t     fwd,
        output wb_t     wb
);

        logic [data_width-1:0]   in_a;
        logic [data_width-1:0]   in_b;
        logic [data_width:0]     sum_full;
        logic [3:0]              cnt;
        logic [2*data_width-1:0] rot_l_full;
        logic [2*data_width-1:0] rot_r_full;
        logic [data_width-1:0]   shftr_out;
        logic [data_width-1:0]   btr_out;
        logic [data_width-1:0]   slbi_out;
        logic [data_width-1:0]   result;
        logic                    ofl_raw;

        // Operand inversion
        assign in_a = ex.inv_a ? ~ex.a_val : ex.a_val;
        assign in_b = ex.inv_b ? ~ex.b_val : ex.b_val;

        // Adder with carry out in the top bit
        assign sum_full = {1'b0, in_a} + {1'b0, in_b} + {{data_width{1'b0}}, ex.cin};

        // Shifter, count from the low bits of B
        assign cnt        = in_b[3:0];
        assign rot_l_full = {in_a, in_a} << cnt;
        assign rot_r_full = {in_a, in_a} >> cnt;

        always_comb begin
                case (ex.op[1:0])
                        2'b00:   shftr_out = rot_l_full[2*data_width-1:data_width];
                        2'b01:   shftr_out = in_a << cnt;
                        2'b10:   shftr_out = rot_r_full[data_width-1:0];
                        default: shftr_out = in_a >> cnt;
                endcase
        end

        always_comb begin
                for (int i = 0; i < data_width; i++) begin
                        btr_out[i] = in_a[data_width-1-i];
                end
        end

        assign slbi_out = (in_a << 8) | in_b;

        // Result select, nop and anything else pass A
        always_comb begin
                case (ex.op)
                        op_rot_l, op_shft_l,
                        op_rot_r, op_shft_r: result = shftr_out;
                        op_add:              result = sum_full[data_width-1:0];
                        op_or:               result = in_a | in_b;
                        op_xor:              result = in_a ^ in_b;
                        op_and:              result = in_a & in_b;
                        op_btr:              result = btr_out;
                        op_lbi:              result = ex.b_val;
                        op_slbi:             result = slbi_out;
                        default:             result = in_a;
                endcase
        end

        // Signed overflow: same input signs, different result sign
        assign ofl_raw = ex.sign ?
                         (in_a[data_width-1] == in_b[data_width-1]) &&
                         (sum_full[data_width-1] != in_a[data_width-1]) :
                         sum_full[data_width];

        always_comb begin
                fwd.valid = ex.valid;
                fwd.rd    = ex.rd;
                fwd.data  = result;
                fwd.wb_en = ex.wb_en;
                fwd.ofl   = (ex.op == op_add) ? ofl_raw : 1'b0;
                fwd.z     = (result == '0);
                fwd.n     = ex.sign & result[data_width-1];
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        wb.valid <= 1'b0;
                        wb.wb_en <= 1'b0;
                end else begin
                        wb <= fwd;
                end
        end

        a_ofl_add_only: assert property (
                @(posedge clk) disable iff (reset)
                (wb.valid && wb.ofl) |-> $past(ex.op) == op_add
        ) else $error("alu: overflow flagged on a non-add operation");

        a_wb_idle_after_reset: assert property (
                @(posedge clk) $past(reset) |-> !wb.valid
        ) else $error("alu: writeback valid right after reset");

endmodule

// File: src/alu_core_top.sv
module alu_core_top
        import alu_pkg::*;
(
        input  logic  clk,
        input  logic  reset,
        input  logic  inst_valid,
        input  inst_t inst,
        output wb_t   wb
);

        logic [reg_addr_width-1:0] ra_addr;
        logic [reg_addr_width-1:0] rb_addr;
        logic [data_width-1:0]     ra_data;
        logic [data_width-1:0]     rb_data;
        dec_op_t                   dec;
        dec_op_t                   ex;
        wb_t                       fwd;

        regfile u_regfile (
                .clk     (clk),
                .reset   (reset),
                .ra_addr (ra_addr),
                .rb_addr (rb_addr),
                .ra_data (ra_data),
                .rb_data (rb_data),
                .wr      (wb)
        );

        inst_decode u_decode (
                .inst_valid (inst_valid),
                .inst       (inst),
                .ra_addr    (ra_addr),
                .rb_addr    (rb_addr),
                .ra_data    (ra_data),
                .rb_data    (rb_data),
                .dec        (dec)
        );

        exec_reg u_exec_reg (
                .clk   (clk),
                .reset (reset),
                .dec   (dec),
                .fwd   (fwd),
                .ex    (ex)
        );

        alu u_alu (
                .clk   (clk),
                .reset (reset),
                .ex    (ex),
                .fwd   (fwd),
                .wb    (wb)
        );

endmodule

// File: testbench/clock_gen.sv
module clock_gen (
        output logic clk,
        output logic reset
);

        timeunit 1ns;
        timeprecision 100ps;

        // 4 ns period
        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        initial begin
                reset = 1'b1;
                repeat (3) @(posedge clk);
                reset <= 1'b0;
        end

endmodule

// File: testbench/tb_alu_core.sv
module tb_alu_core
        import alu_pkg::*;
();

        timeunit 1ns;
        timeprecision 100ps;

        // Directed and random cycles that size the watchdog
        localparam int run_cycles = 445;

        logic  clk;
        logic  reset;
        logic  inst_valid;
        inst_t inst;
        wb_t   wb;

        logic [data_width-1:0] model_regs [reg_count];
        wb_t                   exp_q [$];
        wb_t                   exp_wb;
        logic [1:0]            valid_pipe;
        int                    mismatches;
        int                    other_errors;

        clock_gen u_clock_gen (
                .clk   (clk),
                .reset (reset)
        );

        alu_core_top uut (
                .clk        (clk),
                .reset      (reset),
                .inst_valid (inst_valid),
                .inst       (inst),
                .wb         (wb)
        );

        function automatic inst_t make_rrr(logic [3:0] op, logic [2:0] rd, logic [2:0] rs,
                                           logic [2:0] rt, logic [2:0] fn);
                inst_t i;
                i.rrr.op = op;
                i.rrr.rd = rd;
                i.rrr.rs = rs;
                i.rrr.rt = rt;
                i.rrr.fn = fn;
                return i;
        endfunction

        function automatic inst_t make_ri(logic [3:0] op, logic [2:0] rd, logic [2:0] rs,
                                          logic [5:0] imm);
                inst_t i;
                i.ri.op  = op;
                i.ri.rd  = rd;
                i.ri.rs  = rs;
                i.ri.imm = imm;
                return i;
        endfunction

        // Reference behavior of one instruction against the model registers
        function automatic wb_t model_exec(inst_t i);
                logic [3:0]  op;
                logic        ri;
                logic        inv_a;
                logic        inv_b;
                logic        sign;
                logic        cin;
                logic [15:0] a;
                logic [15:0] b;
                logic [15:0] res;
                logic [16:0] sum;
                logic [3:0]  c;
                wb_t         w;
                op = i.rrr.op;
                if (op > op_slbi && op != op_nop) begin
                        op = op_nop;
                end
                ri = (op <= op_shft_r) || (op == op_lbi) || (op == op_slbi);
                a  = model_regs[i.ri.rs];
                if (ri) begin
                        if (op == op_lbi) begin
                                b = {{10{i.ri.imm[5]}}, i.ri.imm};
                        end else begin
                                b = {10'd0, i.ri.imm};
                        end
                        inv_a = 1'b0;
                        inv_b = 1'b0;
                        sign  = 1'b1;
                end else begin
                        b     = model_regs[i.rrr.rt];
                        inv_a = i.rrr.fn[2];
                        inv_b = i.rrr.fn[1];
                        sign  = i.rrr.fn[0];
                end
                cin = inv_a | inv_b;
                if (inv_a) begin
                        a = ~a;
                end
                if (inv_b) begin
                        b = ~b;
                end
                c   = b[3:0];
                sum = {1'b0, a} + {1'b0, b} + {16'd0, cin};
                case (op)
                        op_rot_l:  res = (a << c) | (a >> (5'd16 - {1'b0, c}));
                        op_shft_l: res = a << c;
                        op_rot_r:  res = (a >> c) | (a << (5'd16 - {1'b0, c}));
                        op_shft_r: res = a >> c;
                        op_add:    res = sum[15:0];
                        op_or:     res = a | b;
                        op_xor:    res = a ^ b;
                        op_and:    res = a & b;
                        op_btr: begin
                                for (int k = 0; k < 16; k++) begin
                                        res[k] = a[15-k];
                                end
                        end
                        op_lbi:    res = b;
                        op_slbi:   res = (a << 8) | b;
                        default:   res = a;
                endcase
                w.valid = 1'b1;
                w.rd    = i.rrr.rd;
                w.data  = res;
                w.wb_en = (op != op_nop);
                if (op == op_add) begin
                        w.ofl = sign ? ((a[15] == b[15]) && (sum[15] != a[15])) : sum[16];
                end else begin
                        w.ofl = 1'b0;
                end
                w.z = (res == 16'd0);
                w.n = sign & res[15];
                return w;
        endfunction

        task automatic issue(inst_t i);
                wb_t w;
                @(posedge clk);
                inst       <= i;
                inst_valid <= 1'b1;
                w = model_exec(i);
                exp_q.push_back(w);
                if (w.wb_en) begin
                        model_regs[w.rd] = w.data;
                end
        endtask

        task automatic idle(int n);
                repeat (n) begin
                        @(posedge clk);
                        inst_valid <= 1'b0;
                        inst       <= inst_t'($urandom);
                end
        endtask

        task automatic report_mismatch(string name, logic [15:0] expected, logic [15:0] got);
                mismatches++;
                $display("MISMATCH %s: expected %h, got %h at %0t", name, expected, got, $time);
        endtask

        // Pre-edge wb values against the queue head
        always @(posedge clk) begin
                // wb.valid follows inst_valid two cycles later
                if (!reset) begin
                        a_valid: assert (wb.valid == valid_pipe[1])
                                else report_mismatch("wb.valid", 16'(valid_pipe[1]),
                                                     16'(wb.valid));
                end
                valid_pipe = {valid_pipe[0], inst_valid};
                if (!reset && wb.valid) begin
                        if (exp_q.size() == 0) begin
                                other_errors++;
                                $display("ERROR: writeback valid with no instruction in flight at %0t",
                                         $time);
                        end else begin
                                exp_wb = exp_q.pop_front();
                                a_rd: assert (wb.rd == exp_wb.rd)
                                        else report_mismatch("wb.rd", 16'(exp_wb.rd), 16'(wb.rd));
                                a_data: assert (wb.data == exp_wb.data)
                                        else report_mismatch("wb.data", exp_wb.data, wb.data);
                                a_wb_en: assert (wb.wb_en == exp_wb.wb_en)
                                        else report_mismatch("wb.wb_en", 16'(exp_wb.wb_en),
                                                             16'(wb.wb_en));
                                a_ofl: assert (wb.ofl == exp_wb.ofl)
                                        else report_mismatch("wb.ofl", 16'(exp_wb.ofl), 16'(wb.ofl));
                                a_z: assert (wb.z == exp_wb.z)
                                        else report_mismatch("wb.z", 16'(exp_wb.z), 16'(wb.z));
                                a_n: assert (wb.n == exp_wb.n)
                                        else report_mismatch("wb.n", 16'(exp_wb.n), 16'(wb.n));
                        end
                end
        end

        initial begin
                #((run_cycles + 20) * 4);
                $display("ERROR: run did not finish in time");
                $display("*** TEST FAILED ***");
                $finish;
        end

        initial begin
                void'($urandom(32'hbf19));
                inst_valid   = 1'b0;
                inst         = '0;
                valid_pipe   = '0;
                mismatches   = 0;
                other_errors = 0;
                for (int r = 0; r < reg_count; r++) begin
                        model_regs[r] = 16'd0;
                end
                while (reset !== 1'b0) begin
                        @(posedge clk);
                end
                idle(3);

                // Every register reads zero after reset
                for (int r = 0; r < reg_count; r++) begin
                        issue(make_rrr(op_or, 3'(r), 3'(r), 3'(r), 3'd0));
                end

                // Operand setup and overflow cases
                issue(make_ri(op_lbi, 3'd1, 3'd0, 6'h3f));
                issue(make_ri(op_lbi, 3'd2, 3'd0, 6'h1f));
                issue(make_ri(op_slbi, 3'd2, 3'd2, 6'h3f));
                issue(make_ri(op_slbi, 3'd2, 3'd2, 6'h3f));
                issue(make_ri(op_lbi, 3'd3, 3'd0, 6'h20));
                issue(make_ri(op_slbi, 3'd3, 3'd3, 6'h00));
                issue(make_ri(op_lbi, 3'd4, 3'd0, 6'h10));
                issue(make_ri(op_slbi, 3'd4, 3'd4, 6'h00));
                issue(make_ri(op_shft_l, 3'd4, 3'd4, 6'd2));
                issue(make_rrr(op_add, 3'd5, 3'd4, 3'd4, 3'b001));
                issue(make_rrr(op_add, 3'd6, 3'd1, 3'd1, 3'b000));

                // Arithmetic and logic across all fn codes
                for (int o = 0; o < 4; o++) begin
                        for (int fn = 0; fn < 8; fn++) begin
                                issue(make_rrr(op_add + 4'(o), 3'(5 + fn % 3), 3'(1 + fn % 4),
                                               3'(1 + (fn + 1) % 4), 3'(fn)));
                        end
                end

                // Shift counts 0 to 15 with varied upper immediate bits
                for (int c = 0; c < 16; c++) begin
                        for (int o = 0; o < 4; o++) begin
                                issue(make_ri(4'(o), 3'd6, 3'(2 + c % 2), 6'(c + 16 * (c % 4))));
                        end
                end
                issue(make_rrr(op_btr, 3'd7, 3'd2, 3'd0, 3'd0));
                issue(make_rrr(op_btr, 3'd7, 3'd3, 3'd0, 3'd0));

                // Immediate loads
                issue(make_ri(op_lbi, 3'd7, 3'd0, 6'h20));
                issue(make_ri(op_lbi, 3'd7, 3'd0, 6'h3f));
                issue(make_ri(op_lbi, 3'd7, 3'd0, 6'h00));
                issue(make_ri(op_lbi, 3'd7, 3'd0, 6'h1f));
                issue(make_ri(op_lbi, 3'd7, 3'd0, 6'h01));
                issue(make_ri(op_slbi, 3'd7, 3'd7, 6'h2a));
                issue(make_ri(op_slbi, 3'd0, 3'd7, 6'h15));

                // Dependent chain followed by nop and undefined opcodes
                issue(make_rrr(op_add, 3'd1, 3'd1, 3'd2, 3'd0));
                issue(make_rrr(op_add, 3'd2, 3'd1, 3'd1, 3'd0));
                issue(make_rrr(op_xor, 3'd3, 3'd2, 3'd1, 3'd0));
                issue(make_rrr(op_add, 3'd4, 3'd3, 3'd1, 3'b101));
                issue(make_rrr(op_and, 3'd5, 3'd4, 3'd4, 3'd0));
                issue(make_rrr(op_nop, 3'd1, 3'd2, 3'd3, 3'd0));
                for (int u = 11; u < 15; u++) begin
                        issue(make_rrr(4'(u), 3'd1, 3'd2, 3'd3, 3'd1));
                end
                issue(make_rrr(op_or, 3'd6, 3'd1, 3'd1, 3'd0));

                // Random traffic with about 70% of cycles valid
                for (int n = 0; n < 300; n++) begin
                        if ($urandom % 10 < 7) begin
                                issue(inst_t'($urandom));
                        end else begin
                                idle(1);
                        end
                end
                idle(4);

                if (exp_q.size() != 0) begin
                        other_errors++;
                        $display("ERROR: %0d expected writebacks never appeared", exp_q.size());
                end
                $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
                if (mismatches == 0 && other_errors == 0) begin
                        $display("*** TEST PASSED ***");
                end else begin
                        $display("*** TEST FAILED ***");
                end
                $finish;
        end

endmodule

// File: build.f
src/alu_pkg.sv
src/regfile.sv
src/inst_decode.sv
src/exec_reg.sv
src/alu.sv
src/alu_core_top.sv
testbench/clock_gen.sv
testbench/tb_alu_core.sv

// File: run.sh
#!/bin/sh
# Build with Verilator and run; pass only if the pass message is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module tb_alu_core -o tb_alu_core &&
./obj_dir/tb_alu_core | grep -F '*** TEST PASSED ***' &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
